// File: logic/tile_renderer_params.svh
`ifndef TILE_RENDERER_PARAMS_SVH
`define TILE_RENDERER_PARAMS_SVH

// tile geometry
`define TILE_SIZE 32
`define TILE_BITS 5

// playfield map, 640x480 screen in 32x32 tiles
`define MAP_COLS 20
`define MAP_ROWS 15

// pixel coordinate width, 0..639 fits
`define COORD_W 10
`define TILE_IDX_W (`COORD_W - `TILE_BITS) // tile column / row part of a coordinate

// one colour channel
`define COLOR_W 8

// tile codes and sprite colour codes share this width
`define CODE_W 3

`endif

// File: logic/screen_geom_pkg.sv
`include "tile_renderer_params.svh"

package screen_geom_pkg;

	// pixel position inside one tile
	typedef logic [`TILE_BITS-1:0] tile_offset_t;

	// a coordinate is either a plain pixel count or a tile index plus offset
	// the low TILE_BITS bits are the offset since tiles are a power of two
	typedef union packed {
		logic [`COORD_W-1:0] value;
		struct packed {
			logic [`TILE_IDX_W-1:0] tile;
			tile_offset_t offset;
		} split;
	} screen_coord_u;

	// codes as written in the map, values 4, 5 and 7 have no pattern
	typedef enum logic [`CODE_W-1:0] {
		TILE_WALL = 3'd0,
		TILE_PATH = 3'd1,
		TILE_ROBOT = 3'd2,
		TILE_LITTER = 3'd3,
		TILE_BLACK = 3'd6
	} tile_code_e;

endpackage

// File: logic/pixel_color_pkg.sv
`include "tile_renderer_params.svh"

package pixel_color_pkg;

	// 3-bit colour code read from a sprite ROM
	typedef logic [`CODE_W-1:0] color_index_t;

	// red in the top channel, then green, then blue
	typedef logic [3*`COLOR_W-1:0] rgb_t;

	localparam rgb_t COL_BLACK = {8'd0, 8'd0, 8'd0};
	localparam rgb_t COL_WHITE = {8'd255, 8'd255, 8'd255};
	localparam rgb_t COL_GREY = {8'd190, 8'd190, 8'd190};
	localparam rgb_t COL_DARK_GREY = {8'd168, 8'd168, 8'd168};
	localparam rgb_t COL_YELLOW = {8'd255, 8'd255, 8'd0};
	localparam rgb_t COL_RED = {8'd255, 8'd0, 8'd0}; // also the "no pattern" colour
	localparam rgb_t COL_BROWN = {8'd92, 8'd64, 8'd51};

endpackage

// File: logic/tile_map_stage.sv
`timescale 1ns/1ps
`include "tile_renderer_params.svh"

module tile_map_stage import screen_geom_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	input logic video_on,
	input screen_coord_u pix_x,
	input screen_coord_u pix_y,
	output tile_code_e tile_code,
	output tile_offset_t offset_x,
	output tile_offset_t offset_y,
	output logic video_on_d
);

	logic [0:`MAP_COLS*`CODE_W-1] map_row; // column 0 in the leftmost octal digit
	logic [6:0] col_base; // bit position of the column's code in map_row
	logic in_map;
	tile_code_e tile_code_next;

	// fixed playfield with one octal digit per tile
	always_comb begin
		case (pix_y.split.tile)
			5'd0: map_row = 60'o0000_0000_0111_1110_0000;
			5'd1: map_row = 60'o0000_0000_0100_0010_0000;
			5'd2: map_row = 60'o0000_0100_0300_0011_1111;
			5'd3: map_row = 60'o0000_0111_1100_0000_0000;
			5'd4: map_row = 60'o0000_0100_0100_0000_1111;
			5'd5: map_row = 60'o0000_0100_0100_0111_1000;
			5'd6: map_row = 60'o1111_1100_0411_1100_0000;
			5'd7: map_row = 60'o1001_1100_0000_1011_1111;
			5'd8: map_row = 60'o2000_0100_0000_1001_0000;
			5'd9: map_row = 60'o6001_1111_1101_1511_0000;
			default: map_row = '0; // rows 10 to 14 are all wall
		endcase
	end

	assign col_base = 7'(pix_x.split.tile) * 7'(`CODE_W);
	assign in_map = (pix_x.split.tile < `MAP_COLS) && (pix_y.split.tile < `MAP_ROWS);

	// off-map coordinates fall back to wall
	always_comb begin
		if (in_map)
			tile_code_next = tile_code_e'(map_row[col_base +: `CODE_W]);
		else
			tile_code_next = TILE_WALL;
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			tile_code <= TILE_WALL;
			offset_x <= '0;
			offset_y <= '0;
			video_on_d <= 1'b0;
		end else begin
			tile_code <= tile_code_next;
			offset_x <= pix_x.split.offset;
			offset_y <= pix_y.split.offset;
			video_on_d <= video_on;
		end
	end

endmodule

// File: logic/tile_pattern_rom.sv
`timescale 1ns/1ps
`include "tile_renderer_params.svh"

module tile_pattern_rom import screen_geom_pkg::*, pixel_color_pkg::*; (
	input tile_code_e tile_code,
	input tile_offset_t offset_x,
	input tile_offset_t offset_y,
	output color_index_t color_index,
	output logic border
);

	logic [0:`TILE_SIZE*`CODE_W-1] robot_row;
	logic [0:`TILE_SIZE*`CODE_W-1] litter_row;
	logic [6:0] x_base; // first bit of the pixel's code in a row

	assign x_base = 7'(offset_x) * 7'(`CODE_W);

	// robot sprite, one octal digit per pixel
	always_comb begin
		case (offset_y)
			5'd0: robot_row = 96'o1111_1111_1111_1111_1111_1111_1111_1111;
			5'd1: robot_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd2: robot_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd3: robot_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd4: robot_row = 96'o1000_0000_0000_0100_0001_0000_0000_0001;
			5'd5: robot_row = 96'o1000_0000_0000_1110_0011_1000_0000_0001;
			5'd6: robot_row = 96'o1000_0000_0001_1211_1112_1100_0000_0001;
			5'd7: robot_row = 96'o1000_0000_0011_2221_1122_2110_0000_0001;
			5'd8: robot_row = 96'o1000_0000_0112_2221_1122_2211_0000_0001;
			5'd9: robot_row = 96'o1000_0000_1122_1122_1221_1221_1000_0001;
			5'd10: robot_row = 96'o1000_0001_1221_3212_1212_3122_1100_0001;
			5'd11: robot_row = 96'o1000_0011_2221_3312_1213_3122_2110_0001;
			5'd12: robot_row = 96'o1000_0012_2222_1122_1221_1222_2210_0001;
			5'd13: robot_row = 96'o1000_0012_2222_2221_6122_2222_2210_0001;
			5'd14: robot_row = 96'o1000_0012_2222_2221_6122_2222_2210_0001;
			5'd15: robot_row = 96'o1000_0001_2222_2211_6112_2222_2100_0001;
			5'd16: robot_row = 96'o1000_0000_1111_1111_6111_1111_1000_0001;
			5'd17: robot_row = 96'o1000_0000_0000_0001_6100_0000_0000_0001;
			5'd18: robot_row = 96'o1000_0000_0006_6666_6666_6600_0000_0001;
			5'd19: robot_row = 96'o1000_0000_6666_3333_3333_3666_6000_0001;
			5'd20: robot_row = 96'o1000_0000_6336_6666_6666_6633_6000_0001;
			5'd21: robot_row = 96'o1000_0000_6334_4111_1111_4433_6000_0001;
			5'd22: robot_row = 96'o1000_0000_6364_4144_4441_4463_6000_0001;
			5'd23: robot_row = 96'o1000_0000_0664_4144_4441_4466_0000_0001;
			5'd24: robot_row = 96'o1000_0000_0114_4144_4551_4411_0000_0001;
			5'd25: robot_row = 96'o1000_0000_0114_4444_4554_4411_0000_0001;
			5'd26: robot_row = 96'o1000_0000_0111_1100_0001_1111_0000_0001;
			5'd27: robot_row = 96'o1000_0000_0111_1100_0001_1111_0000_0001;
			5'd28: robot_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd29: robot_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd30: robot_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			default: robot_row = 96'o1111_1111_1111_1111_1111_1111_1111_1111; // row 31
		endcase
	end

	// litter item, a bottle with a red label
	always_comb begin
		case (offset_y)
			5'd0: litter_row = 96'o1111_1111_1111_1111_1111_1111_1111_1111;
			5'd1: litter_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd2: litter_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd3: litter_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd4: litter_row = 96'o1000_0000_0000_1100_0000_0000_0000_0001;
			5'd5: litter_row = 96'o1000_0000_0001_3310_0000_0000_0000_0001;
			5'd6: litter_row = 96'o1000_0000_0001_3231_0000_0000_0000_0001;
			5'd7: litter_row = 96'o1000_0000_0001_3221_0000_0000_0000_0001;
			5'd8: litter_row = 96'o1000_0000_0001_2210_0000_0000_0000_0001;
			5'd9: litter_row = 96'o1000_0000_0001_1110_0000_0000_0000_0001;
			5'd10: litter_row = 96'o1000_0000_0112_2221_1000_0000_0000_0001;
			5'd11: litter_row = 96'o1000_0000_1333_3332_2100_0000_0000_0001;
			5'd12: litter_row = 96'o1000_0001_3333_3333_3211_0000_0000_0001;
			5'd13: litter_row = 96'o1000_0013_3333_3333_3322_1000_0000_0001;
			5'd14: litter_row = 96'o1000_0013_3333_3333_3322_2100_0000_0001;
			5'd15: litter_row = 96'o1000_0013_3333_4443_3322_2100_0000_0001;
			5'd16: litter_row = 96'o1000_0133_3333_4443_3322_2210_0000_0001;
			5'd17: litter_row = 96'o1000_0133_3333_4443_3222_2210_0000_0001;
			5'd18: litter_row = 96'o1000_0133_3333_4443_2222_2221_0000_0001;
			5'd19: litter_row = 96'o1000_0133_3333_4442_2222_2221_0000_0001;
			5'd20: litter_row = 96'o1000_1223_3333_4443_3222_2221_0000_0001;
			5'd21: litter_row = 96'o1000_1333_3333_4443_3322_2221_0000_0001;
			5'd22: litter_row = 96'o1000_1333_3333_3333_3322_2221_0000_0001;
			5'd23: litter_row = 96'o1000_1233_3333_3333_3222_2221_0000_0001;
			5'd24: litter_row = 96'o1000_0122_2333_3322_2222_2221_0000_0001;
			5'd25: litter_row = 96'o1000_0012_2222_2222_2222_2210_0000_0001;
			5'd26: litter_row = 96'o1000_0011_2222_2222_2211_1100_0000_0001;
			5'd27: litter_row = 96'o1000_0000_1111_1111_1100_0000_0000_0001;
			5'd28: litter_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd29: litter_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			5'd30: litter_row = 96'o1000_0000_0000_0000_0000_0000_0000_0001;
			default: litter_row = 96'o1111_1111_1111_1111_1111_1111_1111_1111;
		endcase
	end

	always_comb begin
		case (tile_code)
			TILE_ROBOT: color_index = robot_row[x_base +: `CODE_W];
			TILE_LITTER: color_index = litter_row[x_base +: `CODE_W];
			default: color_index = '0; // no sprite
		endcase
	end

	// one pixel frame around every tile, used by wall and path
	assign border = (offset_x == 0) || (offset_x == `TILE_SIZE - 1) ||
		(offset_y == 0) || (offset_y == `TILE_SIZE - 1);

endmodule

// File: logic/pixel_palette.sv
`timescale 1ns/1ps
`include "tile_renderer_params.svh"

module pixel_palette import screen_geom_pkg::*, pixel_color_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	input logic video_on,
	input tile_code_e tile_code,
	input color_index_t color_index,
	input logic border,
	output rgb_t rgb
);

	rgb_t rgb_next;
	rgb_t robot_color;
	rgb_t litter_color;

	// robot palette
	always_comb begin
		case (color_index)
			3'd0: robot_color = COL_GREY; // background
			3'd1: robot_color = COL_BLACK; // outline
			3'd2: robot_color = COL_WHITE;
			3'd3: robot_color = COL_DARK_GREY;
			3'd4: robot_color = COL_YELLOW; // body
			3'd5: robot_color = COL_RED;
			3'd6: robot_color = COL_BROWN; // tracks and neck
			default: robot_color = COL_WHITE;
		endcase
	end

	// litter palette, codes 5 to 7 are unused and show white
	always_comb begin
		case (color_index)
			3'd0: litter_color = COL_GREY;
			3'd1: litter_color = COL_BLACK;
			3'd2: litter_color = COL_DARK_GREY; // shading
			3'd3: litter_color = COL_GREY;
			3'd4: litter_color = COL_RED; // label
			default: litter_color = COL_WHITE;
		endcase
	end

	always_comb begin
		if (!video_on) begin
			rgb_next = COL_BLACK; // blanking
		end else begin
			case (tile_code)
				TILE_ROBOT: rgb_next = robot_color;
				TILE_LITTER: rgb_next = litter_color;
				TILE_BLACK: rgb_next = COL_BLACK;
				TILE_PATH: rgb_next = border ? COL_BLACK : COL_GREY;
				TILE_WALL: rgb_next = border ? COL_BLACK : COL_WHITE;
				default: rgb_next = COL_RED; // code without a pattern
			endcase
		end
	end

	// second pipeline stage
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n)
			rgb <= COL_BLACK;
		else
			rgb <= rgb_next;
	end

endmodule

// File: logic/tile_renderer.sv
`timescale 1ns/1ps
`include "tile_renderer_params.svh"

module tile_renderer import screen_geom_pkg::*, pixel_color_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	input logic video_on,
	input screen_coord_u pix_x,
	input screen_coord_u pix_y,
	output logic [`COLOR_W-1:0] graph_r,
	output logic [`COLOR_W-1:0] graph_g,
	output logic [`COLOR_W-1:0] graph_b
);

	tile_code_e tile_code;
	tile_offset_t offset_x;
	tile_offset_t offset_y;
	logic video_on_d; // video_on aligned with stage 1 outputs
	color_index_t color_index;
	logic border;
	rgb_t rgb;

	tile_map_stage tile_map_stage_inst (
		.clock_50(clock_50),
		.arst_n(arst_n),
		.video_on(video_on),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.tile_code(tile_code),
		.offset_x(offset_x),
		.offset_y(offset_y),
		.video_on_d(video_on_d)
	);

	tile_pattern_rom tile_pattern_rom_inst (
		.tile_code(tile_code),
		.offset_x(offset_x),
		.offset_y(offset_y),
		.color_index(color_index),
		.border(border)
	);

	pixel_palette pixel_palette_inst (
		.clock_50(clock_50),
		.arst_n(arst_n),
		.video_on(video_on_d),
		.tile_code(tile_code),
		.color_index(color_index),
		.border(border),
		.rgb(rgb)
	);

	assign graph_r = rgb[3*`COLOR_W-1 -: `COLOR_W];
	assign graph_g = rgb[2*`COLOR_W-1 -: `COLOR_W];
	assign graph_b = rgb[`COLOR_W-1:0];

endmodule

// File: verification/tile_renderer_checks.svh
`ifndef TILE_RENDERER_CHECKS_SVH
`define TILE_RENDERER_CHECKS_SVH

// whole pixel colour at the DUT outputs
task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
	if (actual !== expected) begin
		error_count++;
		$display("Mismatch %s expected %h (r=%0d g=%0d b=%0d) actual %h (r=%0d g=%0d b=%0d)",
			name,
			expected, expected[23:16], expected[15:8], expected[7:0],
			actual, actual[23:16], actual[15:8], actual[7:0]);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first error");
	end
endtask

// registered tile code of the map stage, one edge after the coordinate
task automatic check_tile(input string name, input tile_code_e expected,
	input tile_code_e actual);
	if (actual !== expected) begin
		error_count++;
		$display("Mismatch %s expected tile code %0d actual tile code %0d",
			name, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first error");
	end
endtask

// anything that is not a wrong value, told in plain words
task automatic report_failure(input string what);
	error_count++;
	$display("%s", what);
	$display("ERRORS FOUND");
	$fatal(1, "run stopped");
endtask

`endif

// File: verification/tile_renderer_tb.sv
`timescale 1ns/1ps
`include "tile_renderer_params.svh"

module tile_renderer_tb import screen_geom_pkg::*, pixel_color_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int LATENCY = 2; // coordinate in to colour out
	localparam int RANDOM_COUNT = 24;
	localparam int MARGIN = 20;
	localparam string PATTERN_FILE = "verification/tile_renderer_patterns.txt";

	// sample tiles for random pixels and their codes in the map
	localparam int RAND_TILE_X[8] = '{0, 9, 0, 0, 9, 13, 5, 5};
	localparam int RAND_TILE_Y[8] = '{0, 0, 6, 9, 6, 9, 12, 12}; // last two in the empty rows
	localparam tile_code_e RAND_TILE_CODE[8] = '{TILE_WALL, TILE_PATH, TILE_PATH, TILE_BLACK,
		tile_code_e'(3'd4), tile_code_e'(3'd5), TILE_WALL, TILE_WALL};

	logic clock_50;
	logic arst_n;
	logic video_on;
	screen_coord_u pix_x;
	screen_coord_u pix_y;
	logic [`COLOR_W-1:0] graph_r;
	logic [`COLOR_W-1:0] graph_g;
	logic [`COLOR_W-1:0] graph_b;

	// patterns as read from the file
	string pat_name[$];
	int pat_x[$];
	int pat_y[$];
	int pat_von[$];
	rgb_t pat_rgb[$];

	// results still in flight and the step that drove each
	string rgb_name_q[$];
	rgb_t rgb_exp_q[$];
	int rgb_issue_q[$];
	string tile_name_q[$];
	tile_code_e tile_exp_q[$];
	int tile_issue_q[$];

	int step_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0; // set once the pattern count is known
	int error_count = 0;
	logic [31:0] rand_state = 32'd70;

	`include "tile_renderer_checks.svh"

	tile_renderer tile_renderer_inst (
		.clock_50(clock_50),
		.arst_n(arst_n),
		.video_on(video_on),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.graph_r(graph_r),
		.graph_g(graph_g),
		.graph_b(graph_b)
	);

	initial begin
		clock_50 = 1'b0;
		forever #50 clock_50 = ~clock_50;
	end

	always @(posedge clock_50) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
			report_failure($sformatf("timeout, run still going after %0d cycles", cycle_limit));
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// colour of a tile without sprite by the palette and border rules
	function automatic rgb_t plain_tile_color(input tile_code_e code, input int ox,
		input int oy, input logic von);
		logic on_edge;
		on_edge = (ox == 0) || (ox == 31) || (oy == 0) || (oy == 31);
		if (!von)
			return COL_BLACK;
		case (code)
			TILE_BLACK: return COL_BLACK;
			TILE_PATH: return on_edge ? COL_BLACK : COL_GREY;
			TILE_WALL: return on_edge ? COL_BLACK : COL_WHITE;
			default: return COL_RED;
		endcase
	endfunction

	task automatic read_patterns();
		int fd;
		int n;
		int count;
		string line;
		string name;
		int x, y, von, r, g, b;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			report_failure({"cannot open the pattern file ", PATTERN_FILE});
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					count = $sscanf(line, "%s %d %d %d %d %d %d", name, x, y, von, r, g, b);
					if (count == 7) begin
						pat_name.push_back(name);
						pat_x.push_back(x);
						pat_y.push_back(y);
						pat_von.push_back(von);
						pat_rgb.push_back({r[7:0], g[7:0], b[7:0]});
					end else if (count > 0) begin
						report_failure({"badly formed line in the pattern file: ", line});
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// compare everything whose latency has run out at this falling edge
	task automatic compare_due();
		rgb_t actual;
		tile_code_e tile_now;
		actual = {graph_r, graph_g, graph_b};
		tile_now = tile_renderer_inst.tile_map_stage_inst.tile_code;
		while (tile_issue_q.size() > 0 && tile_issue_q[0] <= step_count - 1) begin
			check_tile(tile_name_q.pop_front(), tile_exp_q.pop_front(), tile_now);
			tile_issue_q.delete(0);
		end
		while (rgb_issue_q.size() > 0 && rgb_issue_q[0] <= step_count - LATENCY) begin
			check_rgb(rgb_name_q.pop_front(), rgb_exp_q.pop_front(), actual);
			rgb_issue_q.delete(0);
		end
	endtask

	// present one pixel and wait for the next falling edge
	task automatic drive_pixel(input string name, input int x, input int y, input logic von,
		input rgb_t exp_rgb, input bit with_tile, input tile_code_e exp_tile);
		pix_x.value = x[`COORD_W-1:0];
		pix_y.value = y[`COORD_W-1:0];
		video_on = von;
		rgb_name_q.push_back(name);
		rgb_exp_q.push_back(exp_rgb);
		rgb_issue_q.push_back(step_count);
		if (with_tile) begin
			tile_name_q.push_back(name);
			tile_exp_q.push_back(exp_tile);
			tile_issue_q.push_back(step_count);
		end
		@(negedge clock_50);
		step_count++;
		compare_due();
	endtask

	task automatic drain_pipeline();
		video_on = 1'b0;
		while (rgb_issue_q.size() > 0 || tile_issue_q.size() > 0) begin
			@(negedge clock_50);
			step_count++;
			compare_due();
		end
	endtask

	// random offsets inside tiles whose colour follows from the border rule
	task automatic run_random_pixels();
		int tx, ty, ox, oy;
		logic von;
		tile_code_e code;
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			rand_state = lcg_next(rand_state);
			tx = RAND_TILE_X[rand_state[26:24]];
			ty = RAND_TILE_Y[rand_state[26:24]];
			code = RAND_TILE_CODE[rand_state[26:24]];
			ox = int'(rand_state[20:16]);
			rand_state = lcg_next(rand_state);
			oy = int'(rand_state[20:16]);
			von = (rand_state[23:21] != 3'd0); // blank about one in eight
			drive_pixel($sformatf("random_%0d", i), tx * `TILE_SIZE + ox, ty * `TILE_SIZE + oy,
				von, plain_tile_color(code, ox, oy, von), 1'b1, code);
		end
	endtask

	initial begin
		arst_n = 1'b0;
		video_on = 1'b0;
		pix_x = '0;
		pix_y = '0;
		read_patterns();
		if (pat_name.size() == 0)
			report_failure("the pattern file holds no patterns");
		cycle_limit = RESET_CYCLES + pat_name.size() + RANDOM_COUNT + LATENCY + MARGIN;

		repeat (RESET_CYCLES) begin
			@(negedge clock_50);
			check_rgb("reset", COL_BLACK, {graph_r, graph_g, graph_b});
		end
		arst_n = 1'b1;

		// first two edges after release still give black
		drive_pixel("post_reset_0", 0, 0, 1'b0, COL_BLACK, 1'b1, TILE_WALL);
		check_rgb("release_edge_1", COL_BLACK, {graph_r, graph_g, graph_b});
		drive_pixel("post_reset_1", 0, 0, 1'b0, COL_BLACK, 1'b0, TILE_WALL);

		for (int i = 0; i < pat_name.size(); i++)
			drive_pixel(pat_name[i], pat_x[i], pat_y[i], pat_von[i] != 0, pat_rgb[i],
				1'b0, TILE_WALL);
		run_random_pixels();
		drain_pipeline();

		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: verification/tile_renderer_patterns.txt
# name pix_x pix_y video_on red green blue, all decimal
# colour is expected two clock edges after the pixel is presented
blank_start 100 100 0 0 0 0
wall_corner 0 0 1 0 0 0
wall_inside 16 16 1 255 255 255
wall_edge_right 31 10 1 0 0 0
path_inside 300 10 1 190 190 190
path_border_top 300 0 1 0 0 0
path_border_left 288 20 1 0 0 0
path_blanked 300 10 0 0 0 0
robot_yellow 11 277 1 255 255 0
robot_brown 16 269 1 92 64 51
robot_red 17 280 1 255 0 0
robot_dark_grey 9 277 1 168 168 168
robot_white 10 269 1 255 255 255
robot_grey 5 277 1 190 190 190
robot_outline 13 277 1 0 0 0
litter_red 300 79 1 255 0 0
litter_grey 296 79 1 190 190 190
litter_dark_grey 306 79 1 168 168 168
litter_outline 294 79 1 0 0 0
litter_background 290 79 1 190 190 190
black_tile 15 303 1 0 0 0
black_tile_corner 0 288 1 0 0 0
code4_inside 303 207 1 255 0 0
code4_corner 288 192 1 255 0 0
code5_inside 421 308 1 255 0 0
row12_wall 100 394 1 255 255 255
row14_border 100 479 1 0 0 0
pipe_robot 11 277 1 255 255 0
pipe_wall 16 16 1 255 255 255
pipe_code5 421 308 1 255 0 0
pipe_path 300 10 1 190 190 190
pipe_blank 421 308 0 0 0 0
pipe_litter 300 79 1 255 0 0

// File: tile_renderer.f
+incdir+logic
+incdir+verification
logic/screen_geom_pkg.sv
logic/pixel_color_pkg.sv
logic/tile_map_stage.sv
logic/tile_pattern_rom.sv
logic/pixel_palette.sv
logic/tile_renderer.sv
verification/tile_renderer_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the tile renderer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tile_renderer.f \
	--top-module tile_renderer_tb -o tile_renderer_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/tile_renderer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
